// ==== hdl/mchan_params.svh ====
// Widths and sizes shared by the DMA command path
// Included by the package and by any module that needs a size
`ifndef MCHAN_PARAMS_SVH
`define MCHAN_PARAMS_SVH

// Command fields
`define MCHAN_SID_WIDTH     2    // Stream id
`define MCHAN_OPC_WIDTH     1    // TX or RX
`define MCHAN_LEN_WIDTH     12   // Bytes minus one
`define TWD_COUNT_WIDTH     12   // Row length, bytes minus one
`define TWD_STRIDE_WIDTH    16   // Row pitch in external memory, minus one

// Address spaces
`define TCDM_ADD_WIDTH      16
`define EXT_ADD_WIDTH       32

// Sizes
`define MCHAN_BURST_LENGTH  64   // Power of two
`define CMD_QUEUE_DEPTH     4

`endif

// ==== hdl/mchan_pkg.sv ====
// Types of the DMA command path
// Modules pull these in with a wildcard import
`include "mchan_params.svh"

package mchan_pkg;

   // Command fields
   typedef logic [`MCHAN_SID_WIDTH-1:0]  sid_t;
   typedef logic [`MCHAN_OPC_WIDTH-1:0]  opc_t;
   typedef logic [`MCHAN_LEN_WIDTH-1:0]  len_t;    // Bytes minus one
   typedef logic [`TWD_COUNT_WIDTH-1:0]  count_t;  // Row bytes minus one
   typedef logic [`TWD_STRIDE_WIDTH-1:0] stride_t; // Row pitch minus one

   // Addresses
   typedef logic [`TCDM_ADD_WIDTH-1:0]   tcdm_add_t;
   typedef logic [`EXT_ADD_WIDTH-1:0]    ext_add_t;

   // Row splitter FSM
   typedef enum logic {
      TRANS_IDLE,
      TRANS_RUN
   } twd_state_e;

   // Burst splitter FSM
   typedef enum logic {
      BURST_IDLE,
      BURST_RUN
   } burst_state_e;

endpackage

// ==== hdl/cmd_queue.sv ====
// Command FIFO in front of the splitters
// Lets software post several transfers while a command is being split
`timescale 1ns/1ps
`include "mchan_params.svh"

module cmd_queue import mchan_pkg::*;
#(
   parameter int unsigned DEPTH = `CMD_QUEUE_DEPTH
)
(
   input  logic      clk_i,
   input  logic      rst_ni,

   // Push side
   input  logic      push_req_i,
   output logic      push_gnt_o,
   input  sid_t      sid_i,
   input  opc_t      opc_i,
   input  len_t      len_i,
   input  logic      inc_i,
   input  logic      twd_i,
   input  count_t    count_i,
   input  stride_t   stride_i,
   input  tcdm_add_t tcdm_add_i,
   input  ext_add_t  ext_add_i,

   // Pop side
   output logic      pop_req_o,
   input  logic      pop_gnt_i,
   output sid_t      sid_o,
   output opc_t      opc_o,
   output len_t      len_o,
   output logic      inc_o,
   output logic      twd_o,
   output count_t    count_o,
   output stride_t   stride_o,
   output tcdm_add_t tcdm_add_o,
   output ext_add_t  ext_add_o
);

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   // Storage, one array per field
   sid_t      mem_sid      [DEPTH];
   opc_t      mem_opc      [DEPTH];
   len_t      mem_len      [DEPTH];
   logic      mem_inc      [DEPTH];
   logic      mem_twd      [DEPTH];
   count_t    mem_count    [DEPTH];
   stride_t   mem_stride   [DEPTH];
   tcdm_add_t mem_tcdm_add [DEPTH];
   ext_add_t  mem_ext_add  [DEPTH];

   logic [PTR_W-1:0] r_wr_ptr;
   logic [PTR_W-1:0] r_rd_ptr;
   logic [CNT_W-1:0] r_count;    // Occupied entries

   logic s_push;
   logic s_pop;

   assign push_gnt_o = (r_count != CNT_W'(DEPTH));  // Low only when full
   assign pop_req_o  = (r_count != '0);
   assign s_push     = push_req_i & push_gnt_o;
   assign s_pop      = pop_req_o & pop_gnt_i;

   //*******************************************************************
   // Pointers and occupancy
   //*******************************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         r_wr_ptr <= '0;
         r_rd_ptr <= '0;
         r_count  <= '0;
      end
      else
      begin
         if (s_push)
            r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
         if (s_pop)
            r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
         if (s_push && !s_pop)
            r_count <= r_count + 1'b1;
         else if (!s_push && s_pop)
            r_count <= r_count - 1'b1;   // Push with pop keeps the count
      end
   end

   // Entry write
   always_ff @(posedge clk_i)
   begin
      if (s_push)
      begin
         mem_sid[r_wr_ptr]      <= sid_i;
         mem_opc[r_wr_ptr]      <= opc_i;
         mem_len[r_wr_ptr]      <= len_i;
         mem_inc[r_wr_ptr]      <= inc_i;
         mem_twd[r_wr_ptr]      <= twd_i;
         mem_count[r_wr_ptr]    <= count_i;
         mem_stride[r_wr_ptr]   <= stride_i;
         mem_tcdm_add[r_wr_ptr] <= tcdm_add_i;
         mem_ext_add[r_wr_ptr]  <= ext_add_i;
      end
   end

   // Head of queue straight to the outputs
   assign sid_o      = mem_sid[r_rd_ptr];
   assign opc_o      = mem_opc[r_rd_ptr];
   assign len_o      = mem_len[r_rd_ptr];
   assign inc_o      = mem_inc[r_rd_ptr];
   assign twd_o      = mem_twd[r_rd_ptr];
   assign count_o    = mem_count[r_rd_ptr];
   assign stride_o   = mem_stride[r_rd_ptr];
   assign tcdm_add_o = mem_tcdm_add[r_rd_ptr];
   assign ext_add_o  = mem_ext_add[r_rd_ptr];

endmodule

// ==== hdl/twd_trans_splitter.sv ====
// Two-dimensional splitter, issues one command per row of a 2D transfer
// Sits between the command FIFO and the burst splitter
`timescale 1ns/1ps

module twd_trans_splitter import mchan_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_ni,

   // Command in
   input  logic      mchan_req_i,
   output logic      mchan_gnt_o,
   input  sid_t      mchan_sid_i,
   input  opc_t      mchan_opc_i,
   input  len_t      mchan_len_i,
   input  logic      mchan_inc_i,
   input  logic      mchan_twd_i,
   input  count_t    mchan_count_i,
   input  stride_t   mchan_stride_i,
   input  tcdm_add_t mchan_tcdm_add_i,
   input  ext_add_t  mchan_ext_add_i,

   // Row out
   output logic      mchan_req_o,
   input  logic      mchan_gnt_i,
   output sid_t      mchan_sid_o,
   output opc_t      mchan_opc_o,
   output len_t      mchan_len_o,
   output logic      mchan_inc_o,
   output tcdm_add_t mchan_tcdm_add_o,
   output ext_add_t  mchan_ext_add_o
);

   // Captured command
   sid_t      r_sid;
   opc_t      r_opc;
   logic      r_inc;
   logic      r_twd;
   count_t    r_count;
   stride_t   r_stride;
   len_t      r_rem_len;    // Bytes still to send, minus one
   tcdm_add_t r_tcdm_add;   // Start of current row
   ext_add_t  r_ext_add;

   twd_state_e cs;
   twd_state_e ns;

   logic s_accept;     // Command taken
   logic s_row_done;   // Row taken downstream
   logic s_last_row;
   len_t s_row_step;   // Row size in bytes

   assign s_accept   = mchan_req_i & mchan_gnt_o;
   assign s_row_done = mchan_req_o & mchan_gnt_i;

   // 1D commands and short remainders go out whole
   assign s_last_row = !r_twd || (r_rem_len <= len_t'(r_count));
   assign s_row_step = len_t'(r_count) + len_t'(1);

   //*******************************************************************
   // Command capture and per-row update
   //*******************************************************************
   always_ff @(posedge clk_i)
   begin
      if (s_accept)
      begin
         r_sid      <= mchan_sid_i;
         r_opc      <= mchan_opc_i;
         r_inc      <= mchan_inc_i;
         r_twd      <= mchan_twd_i;
         r_count    <= mchan_count_i;
         r_stride   <= mchan_stride_i;
         r_rem_len  <= mchan_len_i;
         r_tcdm_add <= mchan_tcdm_add_i;
         r_ext_add  <= mchan_ext_add_i;
      end
      else if (s_row_done && !s_last_row)
      begin
         // Next row, TCDM packed and external strided
         r_rem_len  <= r_rem_len - s_row_step;
         r_tcdm_add <= r_tcdm_add + tcdm_add_t'(s_row_step);
         r_ext_add  <= r_ext_add + ext_add_t'(r_stride) + ext_add_t'(1);
      end
   end

   //*******************************************************************
   // FSM
   //*******************************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         cs <= TRANS_IDLE;
      else
         cs <= ns;
   end

   always_comb
   begin
      ns          = cs;
      mchan_gnt_o = 1'b0;
      mchan_req_o = 1'b0;
      case (cs)
         TRANS_IDLE:
         begin
            // Take a command only when downstream can take a row
            mchan_gnt_o = mchan_gnt_i;
            if (mchan_req_i && mchan_gnt_i)
               ns = TRANS_RUN;
         end
         TRANS_RUN:
         begin
            mchan_req_o = mchan_gnt_i;              // Wait for gnt before req
            if (mchan_gnt_i && s_last_row)
               ns = TRANS_IDLE;                     // Last row leaves now
         end
         default:
         begin
            ns = TRANS_IDLE;
         end
      endcase
   end

   // Row fields, stable while the FSM is in TRANS_RUN
   assign mchan_sid_o      = r_sid;
   assign mchan_opc_o      = r_opc;
   assign mchan_inc_o      = r_inc;
   assign mchan_len_o      = s_last_row ? r_rem_len : len_t'(r_count);
   assign mchan_tcdm_add_o = r_tcdm_add;
   assign mchan_ext_add_o  = r_ext_add;

endmodule

// ==== hdl/burst_splitter.sv ====
// Burst splitter, cuts each row so no piece crosses an external burst boundary
// Last stage of the command path
`timescale 1ns/1ps
`include "mchan_params.svh"

module burst_splitter import mchan_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_ni,

   // Row in
   input  logic      row_req_i,
   output logic      row_gnt_o,
   input  sid_t      row_sid_i,
   input  opc_t      row_opc_i,
   input  len_t      row_len_i,
   input  logic      row_inc_i,
   input  tcdm_add_t row_tcdm_add_i,
   input  ext_add_t  row_ext_add_i,

   // Piece out
   output logic      out_req_o,
   input  logic      out_gnt_i,
   output sid_t      out_sid_o,
   output opc_t      out_opc_o,
   output len_t      out_len_o,
   output logic      out_inc_o,
   output tcdm_add_t out_tcdm_add_o,
   output ext_add_t  out_ext_add_o
);

   localparam int unsigned OFS_W = $clog2(`MCHAN_BURST_LENGTH);  // Offset bits in a burst

   burst_state_e cs;
   burst_state_e ns;

   // Current row
   sid_t      r_sid;
   opc_t      r_opc;
   logic      r_inc;
   len_t      r_rem_len;     // Bytes left in row, minus one
   tcdm_add_t r_tcdm_add;
   ext_add_t  r_ext_add;

   logic s_accept;
   logic s_piece_done;
   logic s_last_piece;
   logic [OFS_W-1:0] s_ofs_inv;   // Inverted offset, burst wide
   len_t s_bound_len;   // Bytes up to the next boundary, minus one
   len_t s_step;        // Bytes of a full-to-boundary piece
   len_t s_piece_len;

   assign s_accept     = row_req_i & row_gnt_o;
   assign s_piece_done = out_req_o & out_gnt_i;

   // Distance to boundary is the inverted offset in minus-one coding
   assign s_ofs_inv    = ~r_ext_add[OFS_W-1:0];
   assign s_bound_len  = len_t'(s_ofs_inv);
   assign s_step       = s_bound_len + len_t'(1);
   assign s_last_piece = (r_rem_len <= s_bound_len);
   assign s_piece_len  = s_last_piece ? r_rem_len : s_bound_len;

   //*******************************************************************
   // Row capture and per-piece update
   //*******************************************************************
   always_ff @(posedge clk_i)
   begin
      if (s_accept)
      begin
         r_sid      <= row_sid_i;
         r_opc      <= row_opc_i;
         r_inc      <= row_inc_i;
         r_rem_len  <= row_len_i;
         r_tcdm_add <= row_tcdm_add_i;
         r_ext_add  <= row_ext_add_i;
      end
      else if (s_piece_done && !s_last_piece)
      begin
         // Both sides move by the piece just sent
         r_rem_len  <= r_rem_len - s_step;
         r_tcdm_add <= r_tcdm_add + tcdm_add_t'(s_step);
         r_ext_add  <= r_ext_add + ext_add_t'(s_step);   // Now burst aligned
      end
   end

   //*******************************************************************
   // FSM
   //*******************************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         cs <= BURST_IDLE;
      else
         cs <= ns;
   end

   always_comb
   begin
      ns = cs;
      case (cs)
         BURST_IDLE:
         begin
            if (row_req_i)
               ns = BURST_RUN;
         end
         BURST_RUN:
         begin
            if (out_gnt_i && s_last_piece)
               ns = BURST_IDLE;
         end
         default:
         begin
            ns = BURST_IDLE;
         end
      endcase
   end

   assign row_gnt_o = (cs == BURST_IDLE);   // One row at a time
   assign out_req_o = (cs == BURST_RUN);

   // Piece fields
   assign out_sid_o      = r_sid;
   assign out_opc_o      = r_opc;
   assign out_inc_o      = r_inc;
   assign out_len_o      = s_piece_len;
   assign out_tcdm_add_o = r_tcdm_add;
   assign out_ext_add_o  = r_ext_add;

endmodule

// ==== hdl/mchan_twd_top.sv ====
// Command path of one DMA channel, FIFO then row splitter then burst splitter
// Commands in on cmd_*, bus-sized pieces out on out_*
`timescale 1ns/1ps
`include "mchan_params.svh"

module mchan_twd_top import mchan_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_ni,

   // Command port
   input  logic      cmd_req_i,
   output logic      cmd_gnt_o,
   input  sid_t      cmd_sid_i,
   input  opc_t      cmd_opc_i,
   input  len_t      cmd_len_i,
   input  logic      cmd_inc_i,
   input  logic      cmd_twd_i,
   input  count_t    cmd_count_i,
   input  stride_t   cmd_stride_i,
   input  tcdm_add_t cmd_tcdm_add_i,
   input  ext_add_t  cmd_ext_add_i,

   // Piece port
   output logic      out_req_o,
   input  logic      out_gnt_i,
   output sid_t      out_sid_o,
   output opc_t      out_opc_o,
   output len_t      out_len_o,
   output logic      out_inc_o,
   output tcdm_add_t out_tcdm_add_o,
   output ext_add_t  out_ext_add_o
);

   //*******************************************************************
   // FIFO to row splitter
   //*******************************************************************
   logic      q_req;
   logic      q_gnt;
   sid_t      q_sid;
   opc_t      q_opc;
   len_t      q_len;
   logic      q_inc;
   logic      q_twd;
   count_t    q_count;
   stride_t   q_stride;
   tcdm_add_t q_tcdm_add;
   ext_add_t  q_ext_add;

   // Row splitter to burst splitter
   logic      row_req;
   logic      row_gnt;
   sid_t      row_sid;
   opc_t      row_opc;
   len_t      row_len;
   logic      row_inc;
   tcdm_add_t row_tcdm_add;
   ext_add_t  row_ext_add;

   cmd_queue #(
      .DEPTH      (`CMD_QUEUE_DEPTH)
   ) i_cmd_queue (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .push_req_i (cmd_req_i),
      .push_gnt_o (cmd_gnt_o),
      .sid_i      (cmd_sid_i),
      .opc_i      (cmd_opc_i),
      .len_i      (cmd_len_i),
      .inc_i      (cmd_inc_i),
      .twd_i      (cmd_twd_i),
      .count_i    (cmd_count_i),
      .stride_i   (cmd_stride_i),
      .tcdm_add_i (cmd_tcdm_add_i),
      .ext_add_i  (cmd_ext_add_i),
      .pop_req_o  (q_req),
      .pop_gnt_i  (q_gnt),
      .sid_o      (q_sid),
      .opc_o      (q_opc),
      .len_o      (q_len),
      .inc_o      (q_inc),
      .twd_o      (q_twd),
      .count_o    (q_count),
      .stride_o   (q_stride),
      .tcdm_add_o (q_tcdm_add),
      .ext_add_o  (q_ext_add)
   );

   twd_trans_splitter i_twd_trans_splitter (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .mchan_req_i      (q_req),
      .mchan_gnt_o      (q_gnt),
      .mchan_sid_i      (q_sid),
      .mchan_opc_i      (q_opc),
      .mchan_len_i      (q_len),
      .mchan_inc_i      (q_inc),
      .mchan_twd_i      (q_twd),
      .mchan_count_i    (q_count),
      .mchan_stride_i   (q_stride),
      .mchan_tcdm_add_i (q_tcdm_add),
      .mchan_ext_add_i  (q_ext_add),
      .mchan_req_o      (row_req),
      .mchan_gnt_i      (row_gnt),
      .mchan_sid_o      (row_sid),
      .mchan_opc_o      (row_opc),
      .mchan_len_o      (row_len),
      .mchan_inc_o      (row_inc),
      .mchan_tcdm_add_o (row_tcdm_add),
      .mchan_ext_add_o  (row_ext_add)
   );

   // Pieces leave the top level directly
   burst_splitter i_burst_splitter (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .row_req_i      (row_req),
      .row_gnt_o      (row_gnt),
      .row_sid_i      (row_sid),
      .row_opc_i      (row_opc),
      .row_len_i      (row_len),
      .row_inc_i      (row_inc),
      .row_tcdm_add_i (row_tcdm_add),
      .row_ext_add_i  (row_ext_add),
      .out_req_o      (out_req_o),
      .out_gnt_i      (out_gnt_i),
      .out_sid_o      (out_sid_o),
      .out_opc_o      (out_opc_o),
      .out_len_o      (out_len_o),
      .out_inc_o      (out_inc_o),
      .out_tcdm_add_o (out_tcdm_add_o),
      .out_ext_add_o  (out_ext_add_o)
   );

endmodule

// ==== verif/tb_mchan_twd_top.sv ====
// Directed testbench for the DMA command path, pieces checked against a reference model
// Top of the simulation, built from the file list in the project root
`timescale 1ns/1ps
`include "mchan_params.svh"

module tb_mchan_twd_top import mchan_pkg::*;
();

   localparam int          CLK_PERIOD = 40;
   localparam int          DRV_DLY    = 2;       // Input drive after rising edge
   localparam int          RST_CYCLES = 3;
   localparam int unsigned BURST      = `MCHAN_BURST_LENGTH;
   localparam int unsigned DEPTH      = `CMD_QUEUE_DEPTH;
   localparam int          CMD_WAIT   = 5000;    // Cycles for one command to be taken
   localparam int          DRAIN_WAIT = 200000;  // Cycles for all pieces to leave
   localparam int          SETTLE     = 10;      // Quiet cycles after the last piece
   localparam int          N_RANDOM   = 40;
   localparam int          SEED       = 80235;

   // out_gnt_i modes
   localparam int GNT_OPEN   = 0;
   localparam int GNT_HOLD   = 1;
   localparam int GNT_RANDOM = 2;

   typedef struct packed {
      sid_t      sid;
      opc_t      opc;
      len_t      len;
      logic      inc;
      logic      twd;
      count_t    count;
      stride_t   stride;
      tcdm_add_t tcdm;
      ext_add_t  ext;
   } cmd_t;

   typedef struct packed {
      sid_t      sid;
      opc_t      opc;
      logic      inc;
      len_t      len;
      tcdm_add_t tcdm;
      ext_add_t  ext;
   } piece_t;

   logic      clk_i = 1'b0;
   logic      rst_ni;
   logic      cmd_req_i;
   logic      cmd_gnt_o;
   sid_t      cmd_sid_i;
   opc_t      cmd_opc_i;
   len_t      cmd_len_i;
   logic      cmd_inc_i;
   logic      cmd_twd_i;
   count_t    cmd_count_i;
   stride_t   cmd_stride_i;
   tcdm_add_t cmd_tcdm_add_i;
   ext_add_t  cmd_ext_add_i;
   logic      out_req_o;
   logic      out_gnt_i;
   sid_t      out_sid_o;
   opc_t      out_opc_o;
   len_t      out_len_o;
   logic      out_inc_o;
   tcdm_add_t out_tcdm_add_o;
   ext_add_t  out_ext_add_o;

   piece_t exp_q[$];         // Pieces still to come, in order
   int     err_cnt      = 0;
   int     piece_cnt    = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;
   bit     stop_run     = 1'b0;   // Set on a timeout, skips later tests
   int     gnt_mode     = GNT_OPEN;

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   mchan_twd_top uut (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .cmd_req_i      (cmd_req_i),
      .cmd_gnt_o      (cmd_gnt_o),
      .cmd_sid_i      (cmd_sid_i),
      .cmd_opc_i      (cmd_opc_i),
      .cmd_len_i      (cmd_len_i),
      .cmd_inc_i      (cmd_inc_i),
      .cmd_twd_i      (cmd_twd_i),
      .cmd_count_i    (cmd_count_i),
      .cmd_stride_i   (cmd_stride_i),
      .cmd_tcdm_add_i (cmd_tcdm_add_i),
      .cmd_ext_add_i  (cmd_ext_add_i),
      .out_req_o      (out_req_o),
      .out_gnt_i      (out_gnt_i),
      .out_sid_o      (out_sid_o),
      .out_opc_o      (out_opc_o),
      .out_len_o      (out_len_o),
      .out_inc_o      (out_inc_o),
      .out_tcdm_add_o (out_tcdm_add_o),
      .out_ext_add_o  (out_ext_add_o)
   );

   //*******************************************************************
   // Compare tasks
   //*******************************************************************
   task automatic check_len(input string what, input len_t got, input len_t exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("FAILED %0t: %s len 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input string what, input tcdm_add_t got_t, input ext_add_t got_e,
                             input tcdm_add_t exp_t, input ext_add_t exp_e);
      if (got_t !== exp_t || got_e !== exp_e)
      begin
         err_cnt++;
         $display("FAILED %0t: %s addr tcdm 0x%04h ext 0x%08h, expected 0x%04h 0x%08h",
                  $time, what, got_t, got_e, exp_t, exp_e);
      end
   endtask

   task automatic check_attr(input string what, input sid_t got_sid, input opc_t got_opc,
                             input logic got_inc, input sid_t exp_sid, input opc_t exp_opc,
                             input logic exp_inc);
      if (got_sid !== exp_sid || got_opc !== exp_opc || got_inc !== exp_inc)
      begin
         err_cnt++;
         $display("FAILED %0t: %s sid/opc/inc %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
                  what, got_sid, got_opc, got_inc, exp_sid, exp_opc, exp_inc);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp)
      begin
         err_cnt++;
         $display("FAILED %0t: %s %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   //*******************************************************************
   // Reference model, row rule then burst rule
   //*******************************************************************
   task automatic model_row(input cmd_t c, input tcdm_add_t tcdm, input ext_add_t ext,
                            input int unsigned bytes);
      int unsigned left;
      int unsigned to_bound;
      int unsigned take;
      piece_t      pc;
      left    = bytes;
      pc.sid  = c.sid;
      pc.opc  = c.opc;
      pc.inc  = c.inc;
      pc.tcdm = tcdm;
      pc.ext  = ext;
      while (left > 0)
      begin
         to_bound = BURST - (pc.ext % BURST);       // Bytes up to next boundary
         take     = (left < to_bound) ? left : to_bound;
         pc.len   = len_t'(take - 1);
         exp_q.push_back(pc);
         left    -= take;
         pc.tcdm  = tcdm_add_t'(pc.tcdm + take);
         pc.ext   = ext_add_t'(pc.ext + take);
      end
   endtask

   task automatic model_cmd(input cmd_t c);
      int unsigned rem;
      int unsigned row;
      tcdm_add_t   t;
      ext_add_t    e;
      rem = int'(c.len) + 1;
      t   = c.tcdm;
      e   = c.ext;
      while (rem > 0)
      begin
         if (c.twd && rem > int'(c.count) + 1)
            row = int'(c.count) + 1;
         else
            row = rem;                              // 1D or last row
         model_row(c, t, e, row);
         rem -= row;
         t    = tcdm_add_t'(t + row);               // TCDM packed
         e    = ext_add_t'(e + c.stride + 1);       // External strided
      end
   endtask

   //*******************************************************************
   // Drivers and waits
   //*******************************************************************
   task automatic step_cycle();
      @(posedge clk_i);
      #DRV_DLY;
   endtask

   task automatic report_timeout(input string what);
      err_cnt++;
      stop_run = 1'b1;
      $display("Timeout at %0t: %s", $time, what);
   endtask

   function automatic cmd_t make_cmd(input sid_t sid, input opc_t opc, input len_t len,
                                     input logic inc, input logic twd, input count_t count,
                                     input stride_t stride, input tcdm_add_t tcdm,
                                     input ext_add_t ext);
      cmd_t c;
      c.sid    = sid;
      c.opc    = opc;
      c.len    = len;
      c.inc    = inc;
      c.twd    = twd;
      c.count  = count;
      c.stride = stride;
      c.tcdm   = tcdm;
      c.ext    = ext;
      return c;
   endfunction

   // Offers one command, gives up after max_wait cycles without gnt
   task automatic try_cmd(input cmd_t c, input int max_wait, output bit ok);
      int n;
      cmd_req_i      = 1'b1;
      cmd_sid_i      = c.sid;
      cmd_opc_i      = c.opc;
      cmd_len_i      = c.len;
      cmd_inc_i      = c.inc;
      cmd_twd_i      = c.twd;
      cmd_count_i    = c.count;
      cmd_stride_i   = c.stride;
      cmd_tcdm_add_i = c.tcdm;
      cmd_ext_add_i  = c.ext;
      n = 0;
      @(negedge clk_i);
      while (!cmd_gnt_o && n < max_wait)
      begin
         @(negedge clk_i);
         n++;
      end
      ok = cmd_gnt_o;          // Registered, so the coming edge takes it
      if (ok)
         model_cmd(c);
      step_cycle();
      cmd_req_i = 1'b0;
   endtask

   task automatic send_cmd(input cmd_t c);
      bit ok;
      try_cmd(c, CMD_WAIT, ok);
      if (!ok)
         report_timeout($sformatf("command was not accepted within %0d cycles", CMD_WAIT));
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_WAIT)
      begin
         step_cycle();
         n++;
      end
      if (exp_q.size() != 0)
      begin
         report_timeout($sformatf("%0d expected pieces never came out during %s",
                                  exp_q.size(), what));
      end
      else
      begin
         // Longer than the pipeline, so a stray row or piece surfaces here
         repeat (SETTLE) step_cycle();
         check_flag("out_req_o after last piece", out_req_o, 1'b0);   // Nothing left over
      end
   endtask

   task automatic close_test(input string name, input int err_start, input int piece_start);
      tests_run++;
      if (err_cnt != err_start)
         tests_failed++;
      $display("%-18s done, %0d pieces, %0d errors", name, piece_cnt - piece_start,
               err_cnt - err_start);
   endtask

   // out_gnt_i driver
   initial
   begin
      out_gnt_i = 1'b0;
      forever
      begin
         step_cycle();
         case (gnt_mode)
            GNT_OPEN: out_gnt_i = 1'b1;
            GNT_HOLD: out_gnt_i = 1'b0;
            default:  out_gnt_i = (($urandom % 4) != 0);   // About 3 in 4 cycles
         endcase
      end
   end

   // Monitor, a piece moves at the next edge when req and gnt are high here
   always @(negedge clk_i)
   begin : monitor
      piece_t exp_pc;
      if (rst_ni === 1'b1 && out_req_o && out_gnt_i)
      begin
         piece_cnt++;
         if (exp_q.size() == 0)
         begin
            err_cnt++;
            $display("FAILED %0t: piece at ext 0x%08h with none expected", $time, out_ext_add_o);
         end
         else
         begin
            exp_pc = exp_q.pop_front();
            check_len("piece", out_len_o, exp_pc.len);
            check_addr("piece", out_tcdm_add_o, out_ext_add_o, exp_pc.tcdm, exp_pc.ext);
            check_attr("piece", out_sid_o, out_opc_o, out_inc_o, exp_pc.sid, exp_pc.opc,
                       exp_pc.inc);
         end
      end
   end

   //*******************************************************************
   // Tests
   //*******************************************************************
   task automatic after_reset();
      int e0;
      e0 = err_cnt;
      check_flag("out_req_o after reset", out_req_o, 1'b0);
      check_flag("cmd_gnt_o after reset", cmd_gnt_o, 1'b1);
      close_test("after_reset", e0, piece_cnt);
   endtask

   task automatic single_burst();
      int e0;
      int p0;
      e0 = err_cnt;
      p0 = piece_cnt;
      // 32 bytes at burst offset 16, stays inside one burst
      send_cmd(make_cmd(2'd1, 1'b0, 12'd31, 1'b1, 1'b0, 12'd0, 16'd0, 16'h0100, 32'h1000_0010));
      wait_drain("single_burst");
      check_count("single_burst pieces", piece_cnt - p0, 1);
      close_test("single_burst", e0, p0);
   endtask

   task automatic row_split();
      int e0;
      int p0;
      e0 = err_cnt;
      p0 = piece_cnt;
      // 70 bytes in rows of 20 with pitch 128, last row 10 bytes
      send_cmd(make_cmd(2'd2, 1'b1, 12'd69, 1'b1, 1'b1, 12'd19, 16'd127, 16'h0200,
                        32'h2000_0000));
      wait_drain("row_split");
      check_count("row_split pieces", piece_cnt - p0, 4);
      close_test("row_split", e0, p0);
   endtask

   task automatic boundary_cut();
      int e0;
      int p0;
      e0 = err_cnt;
      p0 = piece_cnt;
      send_cmd(make_cmd(2'd3, 1'b0, 12'd99, 1'b1, 1'b0, 12'd0, 16'd0, 16'h0300,
                        32'h3000_0030));    // 16 + 64 + 20
      send_cmd(make_cmd(2'd0, 1'b1, 12'd95, 1'b0, 1'b1, 12'd47, 16'd63, 16'h0400,
                        32'h4000_0020));    // Two rows of 48, each cut at 32
      wait_drain("boundary_cut");
      check_count("boundary_cut pieces", piece_cnt - p0, 7);
      close_test("boundary_cut", e0, p0);
   endtask

   task automatic queue_backpressure();
      int   e0;
      int   p0;
      int   accepted;
      bit   ok;
      bit   stalled;
      cmd_t c;
      e0       = err_cnt;
      p0       = piece_cnt;
      accepted = 0;
      stalled  = 1'b0;
      gnt_mode = GNT_HOLD;
      step_cycle();
      step_cycle();                         // out_gnt_i now low
      for (int i = 0; i < int'(DEPTH) + 2 && !stalled; i++)
      begin
         c = make_cmd(sid_t'(i), opc_t'(i), len_t'(40 + 8*i), 1'b1, i[0], 12'd15, 16'd99,
                      tcdm_add_t'(16'h0800 + 256*i), ext_add_t'(32'h5000_0008 + 1024*i));
         try_cmd(c, 10, ok);
         if (ok)
            accepted++;
         else
            stalled = 1'b1;
      end
      if (!stalled || accepted > int'(DEPTH) + 1)
      begin
         err_cnt++;
         $display("FAILED %0t: cmd_gnt_o stayed high for %0d accepted commands", $time,
                  accepted);
      end
      check_flag("cmd_gnt_o with outputs blocked", cmd_gnt_o, 1'b0);
      gnt_mode = GNT_RANDOM;
      wait_drain("queue_backpressure");
      gnt_mode = GNT_OPEN;
      close_test("queue_backpressure", e0, p0);
   endtask

   task automatic random_traffic();
      int   e0;
      int   p0;
      cmd_t c;
      e0       = err_cnt;
      p0       = piece_cnt;
      gnt_mode = GNT_RANDOM;
      for (int i = 0; i < N_RANDOM && !stop_run; i++)
      begin
         c.sid    = sid_t'($urandom);
         c.opc    = opc_t'($urandom);
         c.inc    = 1'($urandom % 2);
         c.twd    = (($urandom % 3) != 0);          // Mostly 2D
         c.count  = count_t'(3 + $urandom % 60);
         c.stride = stride_t'(c.count + $urandom % 200);
         c.len    = len_t'($urandom % 320);
         c.tcdm   = tcdm_add_t'($urandom);
         c.ext    = ext_add_t'($urandom);
         send_cmd(c);
      end
      wait_drain("random_traffic");
      gnt_mode = GNT_OPEN;
      close_test("random_traffic", e0, p0);
   endtask

   //*******************************************************************
   // Main sequence
   //*******************************************************************
   initial
   begin
      void'($urandom(SEED));
      rst_ni         = 1'b0;
      cmd_req_i      = 1'b0;
      cmd_sid_i      = '0;
      cmd_opc_i      = '0;
      cmd_len_i      = '0;
      cmd_inc_i      = 1'b0;
      cmd_twd_i      = 1'b0;
      cmd_count_i    = '0;
      cmd_stride_i   = '0;
      cmd_tcdm_add_i = '0;
      cmd_ext_add_i  = '0;
      repeat (RST_CYCLES) @(posedge clk_i);
      #DRV_DLY;
      rst_ni = 1'b1;
      step_cycle();

      after_reset();
      if (!stop_run)
         single_burst();
      if (!stop_run)
         row_split();
      if (!stop_run)
         boundary_cut();
      if (!stop_run)
         queue_backpressure();
      if (!stop_run)
         random_traffic();

      $display("tests %0d, failed %0d, pieces %0d, errors %0d", tests_run, tests_failed,
               piece_cnt, err_cnt);
      if (err_cnt == 0 && !stop_run)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== mchan_twd_top.f ====
// Header folder for the shared `define file
+incdir+hdl
// RTL in compile order, package first
hdl/mchan_pkg.sv
hdl/cmd_queue.sv
hdl/twd_trans_splitter.sv
hdl/burst_splitter.sv
hdl/mchan_twd_top.sv
// Testbench
verif/tb_mchan_twd_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the DMA command path testbench with Verilator and runs it
# Exit status is zero only when the simulation log holds the pass line
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal --top-module tb_mchan_twd_top \
   -f mchan_twd_top.f -o tb_mchan_twd_top > build.log 2>&1 \
   && ./obj_dir/tb_mchan_twd_top > "$LOG" 2>&1 \
   || echo "Build or simulation did not complete, see build.log and $LOG"

grep -qx "sim passed" "$LOG" 2>/dev/null && echo "PASS" && exit 0
echo "FAIL"
exit 1
